/* build.f */
design/fetch_cfg_pkg.sv
design/fetch_types_pkg.sv
design/fetch_pc_gen.sv
design/fetch_addr_queue.sv
design/fetch_output_stage.sv
design/fetch_unit.sv
verif/fetch_unit_tb.sv

/* design/fetch_addr_queue.sv */
// Outstanding fetch address queue
// Circular buffer holding the address of every request still waiting for
// its memory answer, oldest at the head; flush drops all entries at once
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_queue (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flush,
	input  logic                             push,
	input  logic [fetch_cfg_pkg::ADDR_W-1:0] push_addr,
	input  logic                             pop,
	output logic [fetch_cfg_pkg::ADDR_W-1:0] head_addr,
	output logic                             full
);
	import fetch_cfg_pkg::*;

	logic [ADDR_W-1:0]      mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W:0]   count;	// One extra bit to tell full from empty
	logic                   empty;
	logic                   do_push;
	logic                   do_pop;

	assign full  = (count == (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
	assign empty = (count == '0);

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign head_addr = mem[rd_ptr];

	// Storage
	always_ff @(posedge iCLOCK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_addr;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap on their own as the depth is a power of two
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/fetch_cfg_pkg.sv */
// Fetch unit configuration
// Address and instruction sizes, PC step, reset vector and the depth
// of the outstanding fetch queue
`default_nettype none

package fetch_cfg_pkg;

	// Bus widths
	localparam int ADDR_W      = 32;
	localparam int INST_W      = 32;
	localparam int MMU_FLAGS_W = 6;	// Flags returned with each word

	// Program counter
	localparam int INST_BYTES = 4;	// One word per fetch
	localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

	// One queue entry per outstanding fetch
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = 3;	// log2 of the depth

endpackage

`default_nettype wire

/* design/fetch_output_stage.sv */
// Fetch output stage
// Pairs each memory answer with the oldest queued address and registers
// instruction, flags and following PC for decode
`timescale 1ns/1ps
`default_nettype none

module fetch_output_stage (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flush,
	input  fetch_types_pkg::mem_resp_t       resp,
	input  logic [fetch_cfg_pkg::ADDR_W-1:0] head_addr,
	input  logic                             next_lock,
	output logic                             accept,
	output fetch_types_pkg::next_inst_t      next
);
	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	next_inst_t bundle;

	// Response is consumed only when decode can take it
	assign accept = resp.valid && !next_lock;

	always_comb begin
		bundle.valid = resp.valid;
		bundle.flags = resp.flags;
		bundle.inst  = resp.inst;
		bundle.pc    = head_addr + ADDR_W'(INST_BYTES);	// Following address
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			next <= '0;
		end else if (flush) begin
			next <= '0;
		end else if (!next_lock) begin
			next <= bundle;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_pc_gen.sv */
// Program counter generator
// Starts at the reset vector, steps one word per issued fetch, halts on an
// exception and restarts from the jump address
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  fetch_types_pkg::except_t    except,
	input  logic                        queue_full,
	input  logic                        mem_busy,
	input  logic                        fetch_stop,
	output fetch_types_pkg::fetch_req_t fetch
);
	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	fetch_state_e      state;
	logic [ADDR_W-1:0] pc;
	logic              req;

	// A fetch leaves only while running and with room to track it
	assign req = (state == FETCH_RUN) && !queue_full && !mem_busy &&
		!fetch_stop && !except.evt;

	assign fetch.req  = req;
	assign fetch.addr = pc;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= FETCH_START;
			pc    <= RESET_PC;
		end else if (except.addr_set) begin	// Jump beats the halt
			state <= FETCH_RUN;
			pc    <= {except.addr[ADDR_W-1:1], 1'b0};
		end else if (except.evt) begin
			state <= FETCH_HALT;
		end else begin
			case (state)
				FETCH_START: begin
					state <= FETCH_RUN;
					pc    <= RESET_PC;
				end
				FETCH_RUN: begin
					// Step only past an address that actually went out
					if (req) begin
						pc <= pc + ADDR_W'(INST_BYTES);
					end
				end
				FETCH_HALT: begin
					state <= FETCH_HALT;	// Left only by a jump
				end
				default: begin
					state <= FETCH_START;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/fetch_types_pkg.sv */
// Fetch unit types
// Request, memory response, decode bundle and exception control as packed
// structs, plus the state encoding of the PC generator
`default_nettype none

package fetch_types_pkg;
	import fetch_cfg_pkg::*;

	typedef enum logic [1:0] {
		FETCH_START = 2'd0,	// Single cycle after reset
		FETCH_RUN   = 2'd1,
		FETCH_HALT  = 2'd2	// Parked until a jump arrives
	} fetch_state_e;

	// Toward instruction memory
	typedef struct packed {
		logic              req;
		logic [ADDR_W-1:0] addr;
	} fetch_req_t;

	// Answer from instruction memory in request order
	typedef struct packed {
		logic                   valid;
		logic [MMU_FLAGS_W-1:0] flags;
		logic [INST_W-1:0]      inst;
	} mem_resp_t;

	// Bundle handed to decode
	typedef struct packed {
		logic                   valid;
		logic [MMU_FLAGS_W-1:0] flags;
		logic [INST_W-1:0]      inst;
		logic [ADDR_W-1:0]      pc;	// Address of the following instruction
	} next_inst_t;

	// Exception control from the core
	typedef struct packed {
		logic              evt;	// Exception event that flushes the fetch path
		logic              addr_set;	// Load PC from addr
		logic [ADDR_W-1:0] addr;
	} except_t;

endpackage

`default_nettype wire

/* design/fetch_unit.sv */
// Instruction fetch unit
// PC generator, outstanding address queue and decode output register for
// a single issue 32-bit pipeline
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  fetch_types_pkg::except_t    except,
	input  logic                        mem_busy,
	input  fetch_types_pkg::mem_resp_t  resp,
	input  logic                        fetch_stop,
	input  logic                        next_lock,
	output fetch_types_pkg::fetch_req_t fetch,
	output logic                        mem_lock,
	output fetch_types_pkg::next_inst_t next
);
	import fetch_cfg_pkg::*;

	logic              queue_full;
	logic              accept;
	logic [ADDR_W-1:0] head_addr;

	// Memory holds its answer while decode is stalled
	assign mem_lock = next_lock;

	fetch_pc_gen u_pc_gen (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.except     (except),
		.queue_full (queue_full),
		.mem_busy   (mem_busy),
		.fetch_stop (fetch_stop),
		.fetch      (fetch)
	);

	// Every issued request records its address here
	fetch_addr_queue u_addr_queue (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (except.evt),
		.push      (fetch.req),
		.push_addr (fetch.addr),
		.pop       (accept),
		.head_addr (head_addr),
		.full      (queue_full)
	);

	fetch_output_stage u_output_stage (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (except.evt),
		.resp      (resp),
		.head_addr (head_addr),
		.next_lock (next_lock),
		.accept    (accept),
		.next      (next)
	);

endmodule

`default_nettype wire

/* verif/fetch_unit_tb.sv */
// Fetch unit testbench
// In-order memory model with random latency, scenario table applied in a
// loop, scoreboard on the decode bundle and on the request address stream
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;
	import fetch_cfg_pkg::*;
	import fetch_types_pkg::*;

	localparam logic [31:0] INST_KEY = 32'h5a3c_96e1;	// Word is address XOR key
	localparam int NUM_ROWS = 7;

	typedef struct packed {
		logic [15:0] cycles;	// Cycle budget for the row
		logic [7:0]  stop_pct;
		logic [7:0]  lock_pct;
		logic [7:0]  busy_pct;
		logic        do_except;
		logic        do_jump;
		logic [31:0] jump_addr;
		logic [15:0] exp_count;	// Deliveries to reach where zero allows none
	} row_t;

	logic       iCLOCK;
	logic       inRESET;
	except_t    except;
	logic       mem_busy;
	mem_resp_t  resp = '0;
	logic       fetch_stop;
	logic       next_lock;
	fetch_req_t fetch;
	logic       mem_lock;
	next_inst_t next;

	row_t        rows [NUM_ROWS];
	logic [31:0] pend_addr [$];	// Requests the memory still owes
	int          pend_ready [$];
	int          mem_cycle;
	int          mem_delay;
	int          deliveries;
	int          error_count;
	int          rows_passed;
	int          rows_failed;
	logic [31:0] exp_pc;	// Address of the next instruction decode should see
	logic [31:0] exp_req;
	logic        halted;

	fetch_unit dut_i (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.except     (except),
		.mem_busy   (mem_busy),
		.resp       (resp),
		.fetch_stop (fetch_stop),
		.next_lock  (next_lock),
		.fetch      (fetch),
		.mem_lock   (mem_lock),
		.next       (next)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic drive_random(input row_t r);
		fetch_stop <= (($urandom % 100) < r.stop_pct);
		next_lock  <= (($urandom % 100) < r.lock_pct);
		mem_busy   <= (($urandom % 100) < r.busy_pct);
		mem_delay  <= 1 + int'($urandom % 3);	// Latency of a request taken now
	endtask

	task automatic drive_quiet();
		fetch_stop <= 1'b0;
		next_lock  <= 1'b0;
		mem_busy   <= 1'b0;
	endtask

	// Instruction memory that answers in order and holds while locked
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			pend_addr.delete();
			pend_ready.delete();
			mem_cycle = 0;
			resp <= '0;
		end else begin
			mem_cycle = mem_cycle + 1;
			if (except.evt) begin
				pend_addr.delete();	// Core flush drops answers in flight
				pend_ready.delete();
				resp <= '0;
			end else begin
				if (fetch.req && !mem_busy) begin
					pend_addr.push_back(fetch.addr);
					pend_ready.push_back(mem_cycle + mem_delay);
				end
				if (!(resp.valid && mem_lock)) begin
					if (resp.valid) begin
						void'(pend_addr.pop_front());	// Taken by the fetch unit
						void'(pend_ready.pop_front());
					end
					if (pend_addr.size() > 0 && pend_ready[0] <= mem_cycle) begin
						resp <= '{valid: 1'b1, flags: pend_addr[0][7:2],
							inst: pend_addr[0] ^ INST_KEY};
					end else begin
						resp <= '0;
					end
				end
			end
		end
	end

	// Scoreboard and per-cycle protocol checks
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			check_value("mem_lock", mem_lock, next_lock);
			if (fetch_stop || mem_busy || halted) begin
				check_value("fetch.req", fetch.req, 1'b0);
			end
			if (halted) begin
				check_value("next.valid", next.valid, 1'b0);
			end
			if (except.evt) begin
				halted = !except.addr_set;
				if (except.addr_set) begin
					exp_pc  = {except.addr[31:1], 1'b0};	// Jump target is halfword aligned
					exp_req = exp_pc;
				end
			end else begin
				if (fetch.req) begin
					check_value("fetch.addr", fetch.addr, exp_req);
					exp_req = exp_req + 32'd4;
				end
				if (next.valid && !next_lock) begin	// Decode takes the bundle
					check_value("next.pc", next.pc, exp_pc + 32'd4);
					check_value("next.inst", next.inst, exp_pc ^ INST_KEY);
					check_value("next.flags", 32'(next.flags), 32'(exp_pc[7:2]));
					exp_pc = exp_pc + 32'd4;
					deliveries <= deliveries + 1;
				end
			end
		end
	end

	initial begin
		row_t r;
		int   start_count;
		int   start_errors;
		int   n;
		int   got;
		logic done;

		void'($urandom(32'h63c3));
		inRESET     = 1'b0;
		except      = '0;
		mem_busy    = 1'b0;
		fetch_stop  = 1'b0;
		next_lock   = 1'b0;
		mem_delay   = 1;
		exp_pc      = RESET_PC;
		exp_req     = RESET_PC;
		halted      = 1'b0;
		deliveries  = 0;
		error_count = 0;
		rows_passed = 0;
		rows_failed = 0;

		// cycles, stop %, lock %, busy %, exception, jump, jump address, deliveries
		rows[0] = '{16'd200, 8'd0, 8'd0, 8'd0, 1'b0, 1'b0, 32'h0, 16'd20};
		rows[1] = '{16'd800, 8'd30, 8'd0, 8'd30, 1'b0, 1'b0, 32'h0, 16'd30};
		rows[2] = '{16'd1000, 8'd10, 8'd40, 8'd10, 1'b0, 1'b0, 32'h0, 16'd40};
		rows[3] = '{16'd1500, 8'd0, 8'd90, 8'd0, 1'b0, 1'b0, 32'h0, 16'd12};	// Queue fills
		rows[4] = '{16'd600, 8'd0, 8'd20, 8'd0, 1'b1, 1'b1, 32'h0000_1235, 16'd16};
		rows[5] = '{16'd40, 8'd0, 8'd0, 8'd0, 1'b1, 1'b0, 32'h0, 16'd0};	// Halt only
		rows[6] = '{16'd800, 8'd20, 8'd30, 8'd20, 1'b1, 1'b1, 32'h0000_2001, 16'd24};

		repeat (16) @(posedge iCLOCK);
		inRESET <= 1'b1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			r = rows[i];
			@(negedge iCLOCK);
			start_errors = error_count;
			@(posedge iCLOCK);
			if (r.do_except) begin
				except <= '{evt: 1'b1, addr_set: r.do_jump, addr: r.jump_addr};
				drive_quiet();
				@(posedge iCLOCK);
				except <= '0;
			end
			start_count = deliveries;
			n = 0;
			done = 1'b0;
			while (!done && n < r.cycles) begin
				@(posedge iCLOCK);
				drive_random(r);
				n++;
				done = (r.exp_count != 0) && (deliveries - start_count >= r.exp_count);
			end
			@(posedge iCLOCK);
			drive_quiet();
			@(negedge iCLOCK);
			got = deliveries - start_count;
			if (r.exp_count != 0 && !done) begin
				$display("Row %0d timed out after %0d cycles with %0d of %0d delivered",
					i, n, got, r.exp_count);
				error_count++;
			end else if (r.exp_count == 0) begin
				check_value("delivered", got, 32'd0);
			end
			if (error_count == start_errors) begin
				rows_passed++;
			end else begin
				rows_failed++;
			end
			$display("Row %0d finished: %0d delivered, %0d errors", i, got,
				error_count - start_errors);
		end

		$display("Rows passed: %0d, rows failed: %0d", rows_passed, rows_failed);
		if (error_count == 0 && rows_failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
